// File: project.f
+incdir+verilog
verilog/core_pkg.sv
verilog/s2_control.sv
verilog/imm_gen.sv
verilog/regfile.sv
verilog/s2_top.sv
tests/tb_s2_top.sv

// File: tests/s2_stim.txt
C W idx data merge (merge 1 shares the cycle of the next I), H expected_halted
C I valid instr illegal format alu cmp rd_we cond uncond imm rs1_data rs2_data
H 0
W 01 11111111 0
W 02 22222222 0
W 05 deadbeef 0
C R format ADD SUB SRL SRA
I 1 002081b3 0 0 0 0 1 0 0 00000000 11111111 22222222
I 1 402081b3 0 0 1 0 1 0 0 00000000 11111111 22222222
I 1 0020d233 0 0 6 0 1 0 0 00000000 11111111 22222222
I 1 4020d233 0 0 7 0 1 0 0 00000000 11111111 22222222
C I format ADDI negative, SRLI, SRAI, ADDI with bit 30 set
I 1 ffb08313 0 1 0 0 1 0 0 fffffffb 11111111 00000000
I 1 0030d393 0 1 6 0 1 0 0 00000003 11111111 00000000
I 1 4030d393 0 1 7 0 1 0 0 00000403 11111111 00000000
I 1 40010413 0 1 0 0 1 0 0 00000400 22222222 00000000
C S format SW offset -8
I 1 fe20ac23 0 2 0 0 0 0 0 fffffff8 11111111 22222222
C B format all six funct3 values, offset -16
I 1 fe2088e3 0 3 0 0 0 1 0 fffffff0 11111111 22222222
I 1 fe2098e3 0 3 0 1 0 1 0 fffffff0 11111111 22222222
I 1 fe20c8e3 0 3 0 4 0 1 0 fffffff0 11111111 22222222
I 1 fe20d8e3 0 3 0 5 0 1 0 fffffff0 11111111 22222222
I 1 fe20e8e3 0 3 0 6 0 1 0 fffffff0 11111111 22222222
I 1 fe20f8e3 0 3 0 7 0 1 0 fffffff0 11111111 22222222
C U format LUI, J format JAL offset -20, JALR
I 1 abcde4b7 0 4 0 0 1 0 0 abcde000 00000000 00000000
I 1 fedff56f 0 5 0 0 1 0 1 ffffffec 00000000 00000000
I 1 00428067 0 1 0 0 1 0 1 00000004 deadbeef 00000000
C Illegal words, zero, all ones, low bits 01, unsupported opcode
I 1 00000000 1 1 0 0 0 0 0 00000000 00000000 00000000
I 1 ffffffff 1 6 0 0 0 0 0 00000000 00000000 00000000
I 1 00000011 1 1 0 0 0 0 0 00000000 00000000 00000000
I 1 00000007 1 6 0 0 0 0 0 00000000 00000000 00000000
C x0 stays zero, then same cycle writeback bypass and readback
W 00 12345678 0
I 1 001001b3 0 0 0 0 1 0 0 00000000 00000000 11111111
W 0a cafef00d 1
I 1 002505b3 0 0 0 0 1 0 0 00000000 cafef00d 22222222
I 1 00a105b3 0 0 0 0 1 0 0 00000000 22222222 cafef00d
C Halt on custom-0, later strobes give no decode
I 0 0000000b 0 0 0 0 0 0 0 00000000 00000000 00000000
H 1
I 0 002081b3 0 0 0 0 0 0 0 00000000 00000000 00000000
I 0 fe2088e3 0 0 0 0 0 0 0 00000000 00000000 00000000
H 1

// File: tests/tb_s2_top.sv
// ==============================
// Stage 2 testbench
// Stim file reader, writeback
// and instruction drivers,
// typed compare tasks
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tb_s2_top;

    localparam int dec_timeout = 20;

    logic                    clk;
    logic                    rst_n;
    logic                    instr_valid;
    core_pkg::word_t         instr;
    logic                    wb_valid;
    core_pkg::reg_idx_t      wb_idx;
    core_pkg::word_t         wb_data;
    logic                    dec_valid;
    logic                    dec_illegal;
    core_pkg::instr_format_e dec_format;
    core_pkg::alu_op_e       dec_alu_op;
    core_pkg::cmp_op_e       dec_cmp_op;
    core_pkg::reg_idx_t      dec_rd;
    core_pkg::reg_idx_t      dec_rs1;
    core_pkg::reg_idx_t      dec_rs2;
    logic                    dec_rd_we;
    logic                    dec_cond_branch;
    logic                    dec_uncond_branch;
    core_pkg::word_t         dec_imm;
    core_pkg::word_t         rs1_data;
    core_pkg::word_t         rs2_data;
    logic                    halted;

    int errors;
    int timeouts;

    // Writeback held back to share a cycle with the next instruction
    logic               pend_wb;
    core_pkg::reg_idx_t pend_idx;
    core_pkg::word_t    pend_data;

    s2_top dut0 (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data),
        .dec_valid(dec_valid), .dec_illegal(dec_illegal), .dec_format(dec_format),
        .dec_alu_op(dec_alu_op), .dec_cmp_op(dec_cmp_op), .dec_rd(dec_rd),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_rd_we(dec_rd_we),
        .dec_cond_branch(dec_cond_branch), .dec_uncond_branch(dec_uncond_branch),
        .dec_imm(dec_imm), .rs1_data(rs1_data), .rs2_data(rs2_data), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string what, input core_pkg::word_t exp,
                              input core_pkg::word_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t: %s expected %h, got %h", $time, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_idx(input string what, input core_pkg::reg_idx_t exp,
                             input core_pkg::reg_idx_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t: %s expected %0d, got %0d", $time, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_format(input string what, input core_pkg::instr_format_e exp,
                                input core_pkg::instr_format_e act);
        if (act !== exp) begin
            $display("[ERROR] %0t: %s expected %0d, got %0d", $time, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_alu(input string what, input core_pkg::alu_op_e exp,
                             input core_pkg::alu_op_e act);
        if (act !== exp) begin
            $display("[ERROR] %0t: %s expected %0d, got %0d", $time, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_cmp(input string what, input core_pkg::cmp_op_e exp,
                             input core_pkg::cmp_op_e act);
        if (act !== exp) begin
            $display("[ERROR] %0t: %s expected %0d, got %0d", $time, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t: %s expected %b, got %b", $time, what, exp, act);
            errors++;
        end
    endtask

    // One-cycle writeback strobe on its own
    task automatic write_reg(input core_pkg::reg_idx_t idx, input core_pkg::word_t data);
        @(posedge clk);
        #1;
        wb_valid = 1'b1;
        wb_idx   = idx;
        wb_data  = data;
        @(posedge clk);
        #1;
        wb_valid = 1'b0;
    endtask

    // One-cycle instruction strobe with any pending writeback alongside
    task automatic issue_instr(input core_pkg::word_t word);
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = word;
        if (pend_wb) begin
            wb_valid = 1'b1;
            wb_idx   = pend_idx;
            wb_data  = pend_data;
            pend_wb  = 1'b0;
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        wb_valid    = 1'b0;
    endtask

    task automatic wait_decode(output logic got);
        int n;
        n = 0;
        while ((dec_valid !== 1'b1) && (n < dec_timeout)) begin
            @(posedge clk);
            #1;
            n++;
        end
        got = (dec_valid === 1'b1);
    endtask

    // Halted stage must never turn a strobe into a decode
    task automatic expect_no_decode();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < dec_timeout; n++) begin
            if (dec_valid === 1'b1)
                seen = 1'b1;
            @(posedge clk);
            #1;
        end
        check_bit("dec_valid while halted", 1'b0, seen);
    endtask

    initial begin
        int          fd;
        int          code;
        logic        done;
        logic        got;
        logic [7:0]  kind;
        logic [8*200-1:0] line;
        logic [31:0] f_v;
        logic [31:0] f_instr;
        logic [31:0] f_ill;
        logic [31:0] f_fmt;
        logic [31:0] f_alu;
        logic [31:0] f_cmp;
        logic [31:0] f_we;
        logic [31:0] f_cb;
        logic [31:0] f_ub;
        logic [31:0] f_imm;
        logic [31:0] f_rs1;
        logic [31:0] f_rs2;
        // Writeback record fields
        logic [31:0] f_idx_w;
        logic [31:0] f_data_w;
        logic [31:0] f_merge_w;

        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        wb_valid    = 1'b0;
        wb_idx      = '0;
        wb_data     = '0;
        errors      = 0;
        timeouts    = 0;
        pend_wb     = 1'b0;
        pend_idx    = '0;
        pend_data   = '0;
        done        = 1'b0;

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        fd = $fopen("tests/s2_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/s2_stim.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            while (!done) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    done = 1'b1;
                end else if (kind == "C") begin
                    code = $fgets(line, fd);
                end else if (kind == "W") begin
                    code = $fscanf(fd, "%h %h %h", f_idx_w, f_data_w, f_merge_w);
                    if (f_merge_w[0]) begin
                        pend_wb   = 1'b1;
                        pend_idx  = f_idx_w[4:0];
                        pend_data = f_data_w;
                    end else begin
                        write_reg(f_idx_w[4:0], f_data_w);
                    end
                end else if (kind == "H") begin
                    code = $fscanf(fd, "%h", f_v);
                    check_bit("halted", f_v[0], halted);
                end else if (kind == "I") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                   f_v, f_instr, f_ill, f_fmt, f_alu, f_cmp,
                                   f_we, f_cb, f_ub, f_imm, f_rs1, f_rs2);
                    issue_instr(f_instr);
                    if (!f_v[0]) begin
                        expect_no_decode();
                    end else begin
                        wait_decode(got);
                        if (!got) begin
                            $display("Timeout: no decode within %0d cycles for instruction %h",
                                     dec_timeout, f_instr);
                            timeouts++;
                        end else begin
                            check_bit("dec_illegal", f_ill[0], dec_illegal);
                            check_format("dec_format",
                                         core_pkg::instr_format_e'(f_fmt[2:0]), dec_format);
                            check_alu("dec_alu_op", core_pkg::alu_op_e'(f_alu[3:0]), dec_alu_op);
                            check_cmp("dec_cmp_op", core_pkg::cmp_op_e'(f_cmp[2:0]), dec_cmp_op);
                            check_bit("dec_rd_we", f_we[0], dec_rd_we);
                            check_bit("dec_cond_branch", f_cb[0], dec_cond_branch);
                            check_bit("dec_uncond_branch", f_ub[0], dec_uncond_branch);
                            // RV32 register fields sit at fixed positions
                            check_idx("dec_rd", f_instr[11:7], dec_rd);
                            check_idx("dec_rs1", f_instr[19:15], dec_rs1);
                            check_idx("dec_rs2", f_instr[24:20], dec_rs2);
                            check_word("dec_imm", f_imm, dec_imm);
                            check_word("rs1_data", f_rs1, rs1_data);
                            check_word("rs2_data", f_rs2, rs2_data);
                        end
                    end
                end else begin
                    $display("Unknown record type in the stimulus file, line skipped");
                    errors++;
                    code = $fgets(line, fd);
                end
            end
            $fclose(fd);

            $display("Mismatches: %0d, timeouts: %0d", errors, timeouts);
            if ((errors == 0) && (timeouts == 0)) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/core_pkg.sv
// ==============================
// Core types for stage 2
// Word and index types, opcode,
// format, ALU and compare enums,
// instruction format union
// ==============================

`default_nettype none

`include "s2_defines.svh"

package core_pkg;

    typedef logic [`S2_XLEN-1:0] word_t;
    typedef logic [`S2_REG_IDX_W-1:0] reg_idx_t;

    // Major opcodes, taken from instr[6:2]
    typedef enum logic [4:0] {
        OPCODE_LOAD     = 5'b00000,
        OPCODE_CUSTOM_0 = 5'b00010,
        OPCODE_MISC_MEM = 5'b00011,
        OPCODE_OP_IMM   = 5'b00100,
        OPCODE_AUIPC    = 5'b00101,
        OPCODE_STORE    = 5'b01000,
        OPCODE_AMO      = 5'b01011,
        OPCODE_OP       = 5'b01100,
        OPCODE_LUI      = 5'b01101,
        OPCODE_BRANCH   = 5'b11000,
        OPCODE_JALR     = 5'b11001,
        OPCODE_JAL      = 5'b11011,
        OPCODE_SYSTEM   = 5'b11100
    } opcode_e;

    typedef enum logic [2:0] {
        INSTR_FORMAT_R,
        INSTR_FORMAT_I,
        INSTR_FORMAT_S,
        INSTR_FORMAT_B,
        INSTR_FORMAT_U,
        INSTR_FORMAT_J,
        INSTR_FORMAT_OTHER
    } instr_format_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // Values match the branch funct3 encoding directly
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_op_e;

    // Field views of one 32-bit instruction, MSB first
    typedef struct packed {
        logic [6:0] funct7; reg_idx_t rs2; reg_idx_t rs1;
        logic [2:0] funct3; reg_idx_t rd; logic [6:0] opcode;
    } r_t;
    typedef struct packed {
        logic [11:0] imm_11_0; reg_idx_t rs1;
        logic [2:0] funct3; reg_idx_t rd; logic [6:0] opcode;
    } i_t;
    typedef struct packed {
        logic [6:0] imm_11_5; reg_idx_t rs2; reg_idx_t rs1;
        logic [2:0] funct3; logic [4:0] imm_4_0; logic [6:0] opcode;
    } s_t;
    typedef struct packed {
        logic imm_12; logic [5:0] imm_10_5; reg_idx_t rs2; reg_idx_t rs1;
        logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
    } b_t;
    typedef struct packed {
        logic [19:0] imm_31_12; reg_idx_t rd; logic [6:0] opcode;
    } u_t;
    typedef struct packed {
        logic imm_20; logic [9:0] imm_10_1; logic imm_11;
        logic [7:0] imm_19_12; reg_idx_t rd; logic [6:0] opcode;
    } j_t;

    typedef union packed {
        r_t r; i_t i; s_t s; b_t b; u_t u; j_t j;
    } instr_u;

endpackage

`default_nettype wire

// File: verilog/imm_gen.sv
// ==============================
// Immediate generator
// Sign-extended I/S/B/J and
// U immediates per format
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "s2_defines.svh"

module imm_gen (
    input  core_pkg::word_t         instr,
    input  core_pkg::instr_format_e format,
    output core_pkg::word_t         imm
);

    core_pkg::instr_u iw;

    // Same word, viewed through whichever format applies
    assign iw = instr;

    always_comb begin
        case (format)
            core_pkg::INSTR_FORMAT_I:
                imm = {{(`S2_XLEN-12){iw.i.imm_11_0[11]}}, iw.i.imm_11_0};
            core_pkg::INSTR_FORMAT_S:
                imm = {{(`S2_XLEN-12){iw.s.imm_11_5[6]}}, iw.s.imm_11_5, iw.s.imm_4_0};
            // Branch offsets are in halfwords, bit 0 is always zero
            core_pkg::INSTR_FORMAT_B:
                imm = {{(`S2_XLEN-12){iw.b.imm_12}}, iw.b.imm_11,
                       iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};
            // Upper immediate, low 12 bits cleared
            core_pkg::INSTR_FORMAT_U:
                imm = {iw.u.imm_31_12, 12'b0};
            core_pkg::INSTR_FORMAT_J:
                imm = {{(`S2_XLEN-20){iw.j.imm_20}}, iw.j.imm_19_12,
                       iw.j.imm_11, iw.j.imm_10_1, 1'b0};
            // R and OTHER carry no immediate
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/regfile.sv
// ==============================
// Integer register file
// 32x32, two registered reads,
// one write, x0 fixed at zero
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "s2_defines.svh"

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rd_en,
    input  core_pkg::reg_idx_t rs1_idx,
    input  core_pkg::reg_idx_t rs2_idx,
    output core_pkg::word_t    rs1_data,
    output core_pkg::word_t    rs2_data,
    input  logic               wb_valid,
    input  core_pkg::reg_idx_t wb_idx,
    input  core_pkg::word_t    wb_data
);

    core_pkg::word_t regs [`S2_NUM_REGS];

    // Read value with x0 forced to zero and same-cycle write forwarded
    function automatic core_pkg::word_t read_port(input core_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (wb_valid && (wb_idx == idx))
            return wb_data;
        else
            return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `S2_NUM_REGS; k++)
                regs[k] <= '0;
            rs1_data <= '0;
            rs2_data <= '0;
        end else begin
            // Writes to x0 are dropped
            if (wb_valid && (wb_idx != '0))
                regs[wb_idx] <= wb_data;
            if (rd_en) begin
                rs1_data <= read_port(rs1_idx);
                rs2_data <= read_port(rs2_idx);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/s2_control.sv
// ==============================
// Stage 2 control
// INIT/RUN/HALT state machine,
// legality and format decode,
// ALU and compare decode,
// registered decode bundle
// ==============================

`timescale 1ns/1ps
`default_nettype none

module s2_control (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  core_pkg::word_t         instr,
    input  core_pkg::word_t         imm,
    output core_pkg::instr_format_e format_comb,
    output logic                    accept,
    output logic                    dec_valid,
    output logic                    dec_illegal,
    output logic                    dec_rd_we,
    output logic                    dec_cond_branch,
    output logic                    dec_uncond_branch,
    output core_pkg::instr_format_e dec_format,
    output core_pkg::alu_op_e       dec_alu_op,
    output core_pkg::cmp_op_e       dec_cmp_op,
    output core_pkg::reg_idx_t      dec_rd,
    output core_pkg::reg_idx_t      dec_rs1,
    output core_pkg::reg_idx_t      dec_rs2,
    output core_pkg::word_t         dec_imm,
    output logic                    halted
);

    typedef enum logic [1:0] {ST_INIT, ST_RUN, ST_HALT} state_e;

    state_e              state_q;
    state_e              state_d;
    core_pkg::opcode_e   opcode;
    logic [2:0]          funct3;
    logic                unsupported;
    logic                illegal;
    logic                halt_req;
    logic                load;
    core_pkg::alu_op_e   alu_op;
    core_pkg::cmp_op_e   cmp_op;
    logic                rd_we;
    logic                cond_branch;
    logic                uncond_branch;

    assign opcode = core_pkg::opcode_e'(instr[6:2]);
    assign funct3 = instr[14:12];

    // Strobes only count in RUN; INIT and HALT drop them
    assign accept   = instr_valid && (state_q == ST_RUN);
    // Custom-0 stands in for a halt and yields no decode
    assign halt_req = accept && (opcode == core_pkg::OPCODE_CUSTOM_0);
    assign load     = accept && !halt_req;
    assign halted   = (state_q == ST_HALT);

    always_comb begin
        case (state_q)
            ST_INIT: state_d = ST_RUN;
            ST_RUN:  state_d = halt_req ? ST_HALT : ST_RUN;
            ST_HALT: state_d = ST_HALT;
            // Unknown encoding, park in HALT
            default: state_d = ST_HALT;
        endcase
    end

    always_comb begin
        unsupported = 1'b0;
        format_comb = core_pkg::INSTR_FORMAT_OTHER;
        case (opcode)
            core_pkg::OPCODE_OP, core_pkg::OPCODE_AMO:
                format_comb = core_pkg::INSTR_FORMAT_R;
            core_pkg::OPCODE_LOAD, core_pkg::OPCODE_MISC_MEM,
            core_pkg::OPCODE_OP_IMM, core_pkg::OPCODE_JALR:
                format_comb = core_pkg::INSTR_FORMAT_I;
            core_pkg::OPCODE_STORE:  format_comb = core_pkg::INSTR_FORMAT_S;
            core_pkg::OPCODE_BRANCH: format_comb = core_pkg::INSTR_FORMAT_B;
            core_pkg::OPCODE_LUI, core_pkg::OPCODE_AUIPC:
                format_comb = core_pkg::INSTR_FORMAT_U;
            core_pkg::OPCODE_JAL:    format_comb = core_pkg::INSTR_FORMAT_J;
            // SYSTEM and CUSTOM_0 are legal but have no fixed format here
            core_pkg::OPCODE_SYSTEM, core_pkg::OPCODE_CUSTOM_0:
                format_comb = core_pkg::INSTR_FORMAT_OTHER;
            default: unsupported = 1'b1;
        endcase
    end

    assign illegal = unsupported || (instr[1:0] != 2'b11)
                  || (instr == '0) || (instr == '1);

    // ALU op; OP_IMM only uses bit 30 for the arithmetic shift
    always_comb begin
        alu_op = core_pkg::ALU_ADD;
        if (opcode == core_pkg::OPCODE_OP || opcode == core_pkg::OPCODE_OP_IMM) begin
            case (funct3)
                3'b000: begin
                    if (opcode == core_pkg::OPCODE_OP && instr[30])
                        alu_op = core_pkg::ALU_SUB;
                end
                3'b001: alu_op = core_pkg::ALU_SLL;
                3'b010: alu_op = core_pkg::ALU_SLT;
                3'b011: alu_op = core_pkg::ALU_SLTU;
                3'b100: alu_op = core_pkg::ALU_XOR;
                3'b101: alu_op = instr[30] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
                3'b110: alu_op = core_pkg::ALU_OR;
                default: alu_op = core_pkg::ALU_AND;
            endcase
        end
    end

    // Compare op and control flags
    always_comb begin
        cmp_op = core_pkg::CMP_EQ;
        if (opcode == core_pkg::OPCODE_BRANCH)
            cmp_op = core_pkg::cmp_op_e'(funct3);
        rd_we = (opcode == core_pkg::OPCODE_OP) || (opcode == core_pkg::OPCODE_OP_IMM)
             || (opcode == core_pkg::OPCODE_LOAD) || (opcode == core_pkg::OPCODE_LUI)
             || (opcode == core_pkg::OPCODE_AUIPC) || (opcode == core_pkg::OPCODE_JAL)
             || (opcode == core_pkg::OPCODE_JALR) || (opcode == core_pkg::OPCODE_AMO);
        cond_branch   = (opcode == core_pkg::OPCODE_BRANCH);
        uncond_branch = (opcode == core_pkg::OPCODE_JAL) || (opcode == core_pkg::OPCODE_JALR);
        // Illegal words must not write or redirect
        if (illegal) begin
            rd_we         = 1'b0;
            cond_branch   = 1'b0;
            uncond_branch = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q           <= ST_INIT;
            dec_valid         <= 1'b0;
            dec_illegal       <= 1'b0;
            dec_rd_we         <= 1'b0;
            dec_cond_branch   <= 1'b0;
            dec_uncond_branch <= 1'b0;
            dec_format        <= core_pkg::INSTR_FORMAT_R;
            dec_alu_op        <= core_pkg::ALU_ADD;
            dec_cmp_op        <= core_pkg::CMP_EQ;
            dec_rd            <= '0;
            dec_rs1           <= '0;
            dec_rs2           <= '0;
            dec_imm           <= '0;
        end else begin
            state_q   <= state_d;
            dec_valid <= load;
            // Bundle holds between strobes
            if (load) begin
                dec_illegal       <= illegal;
                dec_rd_we         <= rd_we;
                dec_cond_branch   <= cond_branch;
                dec_uncond_branch <= uncond_branch;
                dec_format        <= format_comb;
                dec_alu_op        <= alu_op;
                dec_cmp_op        <= cmp_op;
                dec_rd            <= instr[11:7];
                dec_rs1           <= instr[19:15];
                dec_rs2           <= instr[24:20];
                dec_imm           <= imm;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/s2_defines.svh
// ==============================
// Stage 2 width macros
// Data width, register index
// width and register count
// ==============================

`ifndef S2_DEFINES_SVH
`define S2_DEFINES_SVH

// Instruction and register data width
`define S2_XLEN 32

// Register index width, enough for x0..x31
`define S2_REG_IDX_W 5

// Architectural integer registers
`define S2_NUM_REGS 32

`endif

// File: verilog/s2_top.sv
// ==============================
// Stage 2 top level
// Control, immediate generator
// and register file
// ==============================

`timescale 1ns/1ps
`default_nettype none

module s2_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  core_pkg::word_t         instr,
    input  logic                    wb_valid,
    input  core_pkg::reg_idx_t      wb_idx,
    input  core_pkg::word_t         wb_data,
    output logic                    dec_valid,
    output logic                    dec_illegal,
    output core_pkg::instr_format_e dec_format,
    output core_pkg::alu_op_e       dec_alu_op,
    output core_pkg::cmp_op_e       dec_cmp_op,
    output core_pkg::reg_idx_t      dec_rd,
    output core_pkg::reg_idx_t      dec_rs1,
    output core_pkg::reg_idx_t      dec_rs2,
    output logic                    dec_rd_we,
    output logic                    dec_cond_branch,
    output logic                    dec_uncond_branch,
    output core_pkg::word_t         dec_imm,
    output core_pkg::word_t         rs1_data,
    output core_pkg::word_t         rs2_data,
    output logic                    halted
);

    core_pkg::instr_format_e format_comb;
    core_pkg::word_t         imm;
    core_pkg::reg_idx_t      rs1_idx;
    core_pkg::reg_idx_t      rs2_idx;
    // Accepted strobe, doubles as the register read enable
    logic                    accept;

    // Source indices sit at fixed bit positions in every format
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];

    s2_control u_control (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .imm(imm),
        .format_comb(format_comb), .accept(accept), .dec_valid(dec_valid),
        .dec_illegal(dec_illegal), .dec_rd_we(dec_rd_we), .dec_cond_branch(dec_cond_branch),
        .dec_uncond_branch(dec_uncond_branch), .dec_format(dec_format),
        .dec_alu_op(dec_alu_op), .dec_cmp_op(dec_cmp_op), .dec_rd(dec_rd),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_imm(dec_imm), .halted(halted)
    );

    imm_gen u_imm_gen (.instr(instr), .format(format_comb), .imm(imm));

    // Read data lands on the same edge as the decode bundle
    regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rd_en(accept), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .wb_valid(wb_valid), .wb_idx(wb_idx),
        .wb_data(wb_data)
    );

endmodule

`default_nettype wire
